// ==== verilog/phy_cmd_pkg.sv ====
/*
 * phy_cmd_pkg: shared definitions of the DDR3 PHY command stage.
 * Command word layout, field widths, vector types and the tristate
 * sequencer state encoding.
 */
package phy_cmd_pkg;

    // widths
    localparam int CMD_WORD_W = 32;            // one command word per mclk
    localparam int ADDR_W     = 15;            // row/column address, 4Gb parts
    localparam int BANK_W     = 3;
    localparam int RCW_W      = 3;             // {ras, cas, we}
    localparam int LANES      = 2;             // ddr half-cycles per mclk
    localparam int TRI_W      = 8;             // tristate bits per mclk
    localparam int TRI_HALF_W = TRI_W / LANES; // one on/off pattern
    localparam int CTRL_W     = 10;            // control bits kept for pauses

    // field positions in the command word (lsb of multi-bit fields)
    localparam int POS_ADDR       = 17;  // 31..17
    localparam int POS_BANK       = 14;  // 16..14
    localparam int POS_RCW        = 11;  // 13..11, positive logic, 0 = nop
    localparam int POS_ODT        = 10;
    localparam int POS_CKE_DIS    = 9;   // xor-ed with ddr_cke
    localparam int POS_SEL        = 8;   // half-cycle carrying the command
    localparam int POS_DQ_EN      = 7;
    localparam int POS_DQS_EN     = 6;
    localparam int POS_DQS_TOGGLE = 5;
    localparam int POS_DCI_EN     = 4;
    localparam int POS_BUF_WR     = 3;
    localparam int POS_BUF_RD     = 2;
    localparam int POS_ADD_PAUSE  = 1;   // reported back, sequencer inserts the pause
    localparam int POS_BUF_RST    = 0;   // rewind external buffer to page start

    // vector types
    typedef logic [CMD_WORD_W-1:0] cmd_word_t;
    typedef logic [ADDR_W-1:0]     ddr_addr_t;  // also carries pause length on nop
    typedef logic [BANK_W-1:0]     ddr_bank_t;
    typedef logic [RCW_W-1:0]      rcw_t;       // {ras, cas, we}
    typedef logic [TRI_W-1:0]      tri_word_t;  // 4 bits per half-cycle, 1 = tristated

    /*
     * tristate sequencer state
     * TRI_OFF  lines released, steady
     * TRI_ON   lines driven, steady
     * TRI_TURN enable changed against the previous cycle
     */
    typedef enum logic [1:0] {
        TRI_OFF  = 2'b00,
        TRI_ON   = 2'b01,
        TRI_TURN = 2'b10
    } tri_state_t;

endpackage

// ==== verilog/phy_cmd_decode.sv ====
/*
 * phy_cmd_decode: splits the command word, reports nop, pause length and
 * sequence end, and keeps address, bank and control bits of the last
 * active command for nop and inserted pause cycles.
 */
`timescale 1ns/1ns

module phy_cmd_decode #(
    parameter int CMD_PAUSE_BITS = 10,  // address bits giving pause length
    parameter int CMD_DONE_BIT   = 10   // address bit marking end of sequence
) (
    input  logic                          mclk,
    input  logic                          mrst,
    input  phy_cmd_pkg::cmd_word_t        cmd_word,
    input  logic                          add_pause,     // repeat last controls, rcw forced to nop
    output logic                          cmd_nop,
    output logic                          cmd_add_pause,
    output logic                          sequence_done,
    output logic [CMD_PAUSE_BITS-1:0]     pause_len,
    output phy_cmd_pkg::rcw_t             rcw,           // positive logic
    output phy_cmd_pkg::ddr_addr_t        addr,
    output phy_cmd_pkg::ddr_bank_t        bank,
    output logic                          odt,
    output logic                          cke_dis,
    output logic                          sel,
    output logic                          dq_en,
    output logic                          dqs_en,
    output logic                          dqs_toggle,
    output logic                          dci_en,
    output logic                          buf_wr,
    output logic                          buf_rd,
    output logic                          buf_rst
);

    phy_cmd_pkg::ddr_addr_t         addr_in;
    phy_cmd_pkg::ddr_bank_t         bank_in;
    phy_cmd_pkg::rcw_t              rcw_in;
    logic [phy_cmd_pkg::CTRL_W-1:0] ctrl_in;
    logic [phy_cmd_pkg::CTRL_W-1:0] ctrl_cur;
    logic                           active;     // real command, not nop and not pause

    phy_cmd_pkg::ddr_addr_t         addr_hold;
    phy_cmd_pkg::ddr_bank_t         bank_hold;
    logic [phy_cmd_pkg::CTRL_W-1:0] ctrl_hold;

    assign addr_in       = cmd_word[phy_cmd_pkg::POS_ADDR +: phy_cmd_pkg::ADDR_W];
    assign bank_in       = cmd_word[phy_cmd_pkg::POS_BANK +: phy_cmd_pkg::BANK_W];
    assign rcw_in        = cmd_word[phy_cmd_pkg::POS_RCW +: phy_cmd_pkg::RCW_W];
    assign cmd_add_pause = cmd_word[phy_cmd_pkg::POS_ADD_PAUSE];

    // same order as the unpack below
    assign ctrl_in = {
        cmd_word[phy_cmd_pkg::POS_ODT],
        cmd_word[phy_cmd_pkg::POS_CKE_DIS],
        cmd_word[phy_cmd_pkg::POS_SEL],
        cmd_word[phy_cmd_pkg::POS_DQ_EN],
        cmd_word[phy_cmd_pkg::POS_DQS_EN],
        cmd_word[phy_cmd_pkg::POS_DQS_TOGGLE],
        cmd_word[phy_cmd_pkg::POS_DCI_EN],
        cmd_word[phy_cmd_pkg::POS_BUF_WR],
        cmd_word[phy_cmd_pkg::POS_BUF_RD],
        cmd_word[phy_cmd_pkg::POS_BUF_RST]
    };

    assign cmd_nop       = (rcw_in == '0) && !add_pause;   // inserted pause is not a nop
    assign active        = (rcw_in != '0) && !add_pause;
    assign sequence_done = cmd_nop && addr_in[CMD_DONE_BIT];
    assign pause_len     = addr_in[CMD_DONE_BIT] ? '0 : addr_in[CMD_PAUSE_BITS-1:0];

    assign rcw      = add_pause ? '0 : rcw_in;
    assign ctrl_cur = add_pause ? ctrl_hold : ctrl_in;  // pause keeps previous settings
    assign addr     = active ? addr_in : addr_hold;     // lines stay calm on nop/pause
    assign bank     = active ? bank_in : bank_hold;

    assign {odt, cke_dis, sel, dq_en, dqs_en, dqs_toggle, dci_en,
            buf_wr, buf_rd, buf_rst} = ctrl_cur;

    always_ff @(posedge mclk) begin
        if (mrst) begin
            addr_hold <= '0;
            bank_hold <= '0;
            ctrl_hold <= '0;
        end else if (active) begin
            addr_hold <= addr_in;
            bank_hold <= bank_in;
            ctrl_hold <= ctrl_in;
        end
    end

    // done bit wins over any pause length the sequencer might wait for
    assert property (@(posedge mclk) disable iff (mrst)
        addr_in[CMD_DONE_BIT] |-> (pause_len == '0));

endmodule

// ==== verilog/phy_cmd_lanes.sv ====
/*
 * phy_cmd_lanes: builds the two half-cycle lanes of command, address,
 * bank, CKE and ODT for the PHY serializers, plus the DCI disables and
 * the DQS toggle data.
 */
`timescale 1ns/1ns

module phy_cmd_lanes (
    input  phy_cmd_pkg::rcw_t                                  rcw,         // positive logic
    input  phy_cmd_pkg::ddr_addr_t                             addr,
    input  phy_cmd_pkg::ddr_bank_t                             bank,
    input  logic                                               odt,
    input  logic                                               cke_dis,
    input  logic                                               sel,         // 0 = first half
    input  logic                                               dqs_toggle,
    input  logic                                               dci_en,
    input  logic                                               ddr_cke,     // global cke
    input  phy_cmd_pkg::tri_word_t                             dqs_pattern, // usually 8'h55
    output phy_cmd_pkg::ddr_addr_t [phy_cmd_pkg::LANES-1:0]    lane_a,
    output phy_cmd_pkg::ddr_bank_t [phy_cmd_pkg::LANES-1:0]    lane_ba,
    output logic [phy_cmd_pkg::LANES-1:0]                      lane_ras,    // active low
    output logic [phy_cmd_pkg::LANES-1:0]                      lane_cas,
    output logic [phy_cmd_pkg::LANES-1:0]                      lane_we,
    output logic [phy_cmd_pkg::LANES-1:0]                      lane_cke,
    output logic [phy_cmd_pkg::LANES-1:0]                      lane_odt,
    output phy_cmd_pkg::tri_word_t                             dqs_data,
    output logic                                               dci_dis_dq,
    output logic                                               dci_dis_dqs
);

    phy_cmd_pkg::rcw_t rcw_n;   // ddr3 pins are active low
    logic              cke;

    assign rcw_n = ~rcw;
    assign cke   = cke_dis ^ ddr_cke;

    always_comb begin
        for (int i = 0; i < phy_cmd_pkg::LANES; i++) begin
            lane_a[i]   = addr;     // address/bank same in both halves
            lane_ba[i]  = bank;
            lane_cke[i] = cke;
            lane_odt[i] = odt;
            if (int'(sel) == i) begin
                {lane_ras[i], lane_cas[i], lane_we[i]} = rcw_n;
            end else begin
                {lane_ras[i], lane_cas[i], lane_we[i]} = 3'b111;  // nop in the other half
            end
        end
    end

    // write leveling: dci_en=1 and odt=1 keeps DCI on DQ only, off on DQS
    assign dci_dis_dq  = ~dci_en;
    assign dci_dis_dqs = dci_dis_dq | odt;

    // low when not toggling, as the write leveling preamble needs
    assign dqs_data = dqs_toggle ? dqs_pattern : '0;

endmodule

// ==== verilog/phy_tri_seq.sv ====
/*
 * phy_tri_seq: tristate timing for one group of I/O lines (DQ or DQS).
 * Steady enable gives a uniform word, a turn on or off substitutes
 * the matching pattern in both half-cycles.
 */
`timescale 1ns/1ns

module phy_tri_seq (
    input  logic                                  mclk,
    input  logic                                  mrst,
    input  logic                                  en,           // 1 = drive lines
    input  logic [phy_cmd_pkg::TRI_HALF_W-1:0]    on_pattern,   // first word when enabling
    input  logic [phy_cmd_pkg::TRI_HALF_W-1:0]    off_pattern,  // first word after disabling
    output phy_cmd_pkg::tri_word_t                tri_ctl       // 1 = tristated
);

    phy_cmd_pkg::tri_state_t prev_state;  // lines in the previous cycle, on or off only
    phy_cmd_pkg::tri_state_t cur_state;

    always_ff @(posedge mclk) begin
        if (mrst) begin
            prev_state <= phy_cmd_pkg::TRI_OFF;     // start tristated
        end else begin
            prev_state <= en ? phy_cmd_pkg::TRI_ON : phy_cmd_pkg::TRI_OFF;
        end
    end

    always_comb begin
        if ((prev_state == phy_cmd_pkg::TRI_ON) != en) begin
            cur_state = phy_cmd_pkg::TRI_TURN;
        end else begin
            cur_state = en ? phy_cmd_pkg::TRI_ON : phy_cmd_pkg::TRI_OFF;
        end
    end

    always_comb begin
        case (cur_state)
            phy_cmd_pkg::TRI_TURN: tri_ctl = en ? {2{on_pattern}} : {2{off_pattern}};
            phy_cmd_pkg::TRI_ON:   tri_ctl = '0;
            default:               tri_ctl = '1;
        endcase
    end

    // only turn cycles may mix driven and released bits
    assert property (@(posedge mclk) disable iff (mrst)
        (cur_state != phy_cmd_pkg::TRI_TURN) |-> (tri_ctl == '0 || tri_ctl == '1));

endmodule

// ==== verilog/phy_cmd.sv ====
/*
 * phy_cmd: DDR3 command stage at half the DDR3 clock. Decodes one command
 * word per mclk into PHY lanes, tristate words and buffer strobes.
 */
`timescale 1ns/1ns

module phy_cmd #(
    parameter int CMD_PAUSE_BITS = 10,  // address bits encoding pause length
    parameter int CMD_DONE_BIT   = 10   // address bit signalling sequence done
) (
    input  logic                                               mclk,
    input  logic                                               mrst,
    input  phy_cmd_pkg::cmd_word_t                             cmd_word,
    input  logic                                               add_pause,
    input  logic                                               ddr_cke,
    input  phy_cmd_pkg::tri_word_t                             dqs_pattern,
    input  logic [phy_cmd_pkg::TRI_HALF_W-1:0]                 dq_tri_on_pattern,
    input  logic [phy_cmd_pkg::TRI_HALF_W-1:0]                 dq_tri_off_pattern,
    input  logic [phy_cmd_pkg::TRI_HALF_W-1:0]                 dqs_tri_on_pattern,
    input  logic [phy_cmd_pkg::TRI_HALF_W-1:0]                 dqs_tri_off_pattern,
    output logic                                               cmd_nop,
    output logic                                               cmd_add_pause,
    output logic [CMD_PAUSE_BITS-1:0]                          pause_len,
    output logic                                               sequence_done,
    output logic                                               buf_wr,
    output logic                                               buf_rd,
    output logic                                               buf_rst,
    output phy_cmd_pkg::ddr_addr_t [phy_cmd_pkg::LANES-1:0]    lane_a,
    output phy_cmd_pkg::ddr_bank_t [phy_cmd_pkg::LANES-1:0]    lane_ba,
    output logic [phy_cmd_pkg::LANES-1:0]                      lane_ras,
    output logic [phy_cmd_pkg::LANES-1:0]                      lane_cas,
    output logic [phy_cmd_pkg::LANES-1:0]                      lane_we,
    output logic [phy_cmd_pkg::LANES-1:0]                      lane_cke,
    output logic [phy_cmd_pkg::LANES-1:0]                      lane_odt,
    output phy_cmd_pkg::tri_word_t                             dqs_data,
    output logic                                               dci_dis_dq,
    output logic                                               dci_dis_dqs,
    output phy_cmd_pkg::tri_word_t                             dq_tri,
    output phy_cmd_pkg::tri_word_t                             dqs_tri
);

    phy_cmd_pkg::rcw_t      rcw;        // current command, 0 during pause
    phy_cmd_pkg::ddr_addr_t addr;       // calm address
    phy_cmd_pkg::ddr_bank_t bank;
    logic                   odt;
    logic                   cke_dis;
    logic                   sel;
    logic                   dq_en;
    logic                   dqs_en;
    logic                   dqs_toggle;
    logic                   dci_en;

    phy_cmd_decode #(
        .CMD_PAUSE_BITS (CMD_PAUSE_BITS),
        .CMD_DONE_BIT   (CMD_DONE_BIT)
    ) decode (
        .mclk, .mrst, .cmd_word, .add_pause,
        .cmd_nop, .cmd_add_pause, .sequence_done, .pause_len,
        .rcw, .addr, .bank,
        .odt, .cke_dis, .sel, .dq_en, .dqs_en, .dqs_toggle, .dci_en,
        .buf_wr, .buf_rd, .buf_rst
    );

    phy_cmd_lanes lanes (
        .rcw, .addr, .bank, .odt, .cke_dis, .sel, .dqs_toggle, .dci_en,
        .ddr_cke, .dqs_pattern,
        .lane_a, .lane_ba, .lane_ras, .lane_cas, .lane_we, .lane_cke, .lane_odt,
        .dqs_data, .dci_dis_dq, .dci_dis_dqs
    );

    phy_tri_seq dq_seq (
        .mclk        (mclk),
        .mrst        (mrst),
        .en          (dq_en),
        .on_pattern  (dq_tri_on_pattern),
        .off_pattern (dq_tri_off_pattern),
        .tri_ctl     (dq_tri)
    );

    phy_tri_seq dqs_seq (
        .mclk        (mclk),
        .mrst        (mrst),
        .en          (dqs_en),
        .on_pattern  (dqs_tri_on_pattern),
        .off_pattern (dqs_tri_off_pattern),
        .tri_ctl     (dqs_tri)
    );

endmodule

// ==== bench/tb_clk_gen.sv ====
/*
 * tb_clk_gen: testbench clock and reset source.
 * mclk runs with a 40 ns period, mrst is held high for the first two cycles.
 */
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PERIOD       = 40,  // ns
    parameter int RESET_CYCLES = 2
) (
    output logic mclk,
    output logic mrst
);

    initial begin
        mclk = 1'b0;
        mrst = 1'b1;
        #(PERIOD * RESET_CYCLES) mrst = 1'b0;  // released on a falling edge
    end

    always #(PERIOD / 2) mclk = ~mclk;

endmodule

// ==== bench/phy_cmd_tb.sv ====
/*
 * phy_cmd_tb: testbench of the DDR3 command stage. Stimulus tasks walk through
 * active commands, nops, inserted pauses, tristate turns and DCI/DQS data,
 * concurrent assertions compare every output with a model of the command rules.
 */
`timescale 1ns/1ns

module phy_cmd_tb;

    localparam int PAUSE_BITS = 10;
    localparam int DONE_BIT   = 10;
    localparam int WAIT_LIMIT = 200;    // ns allowed for any single wait
    localparam int SEED       = 32'hffd;
    localparam int HW         = phy_cmd_pkg::TRI_HALF_W;

    logic                                            mclk;
    logic                                            mrst;
    phy_cmd_pkg::cmd_word_t                          cmd_word;
    logic                                            add_pause;
    logic                                            ddr_cke;
    phy_cmd_pkg::tri_word_t                          dqs_pattern;
    logic [HW-1:0]                                   dq_on;
    logic [HW-1:0]                                   dq_off;
    logic [HW-1:0]                                   dqs_on;
    logic [HW-1:0]                                   dqs_off;
    logic                                            cmd_nop;
    logic                                            cmd_add_pause;
    logic [PAUSE_BITS-1:0]                           pause_len;
    logic                                            sequence_done;
    logic                                            buf_wr;
    logic                                            buf_rd;
    logic                                            buf_rst;
    phy_cmd_pkg::ddr_addr_t [phy_cmd_pkg::LANES-1:0] lane_a;
    phy_cmd_pkg::ddr_bank_t [phy_cmd_pkg::LANES-1:0] lane_ba;
    logic [phy_cmd_pkg::LANES-1:0]                   lane_ras;
    logic [phy_cmd_pkg::LANES-1:0]                   lane_cas;
    logic [phy_cmd_pkg::LANES-1:0]                   lane_we;
    logic [phy_cmd_pkg::LANES-1:0]                   lane_cke;
    logic [phy_cmd_pkg::LANES-1:0]                   lane_odt;
    phy_cmd_pkg::tri_word_t                          dqs_data;
    logic                                            dci_dis_dq;
    logic                                            dci_dis_dqs;
    phy_cmd_pkg::tri_word_t                          dq_tri;
    phy_cmd_pkg::tri_word_t                          dqs_tri;

    // reference model state, updated once per driven cycle
    phy_cmd_pkg::cmd_word_t rec_word;   // last active command
    phy_cmd_pkg::cmd_word_t prev_ctl;   // control source of the previous cycle
    int                     fall_cnt;
    int                     err_cnt;
    int                     tests_ok;
    int                     tests_bad;

    // expected responses
    phy_cmd_pkg::rcw_t                               cur_rcw;
    phy_cmd_pkg::ddr_addr_t                          cur_addr;
    logic                                            cur_active;
    phy_cmd_pkg::cmd_word_t                          exp_ctl;   // source of control bits
    phy_cmd_pkg::cmd_word_t                          exp_loc;   // source of address and bank
    phy_cmd_pkg::rcw_t                               exp_rcw;
    logic                                            exp_sel;
    logic [3*phy_cmd_pkg::LANES-1:0]                 exp_cmd;   // {ras, cas, we} lanes
    phy_cmd_pkg::ddr_addr_t [phy_cmd_pkg::LANES-1:0] exp_lane_a;
    phy_cmd_pkg::ddr_bank_t [phy_cmd_pkg::LANES-1:0] exp_lane_ba;
    logic [phy_cmd_pkg::LANES-1:0]                   exp_cke;
    logic [phy_cmd_pkg::LANES-1:0]                   exp_odt;
    logic [2:0]                                      exp_buf;   // {wr, rd, rst}
    logic                                            exp_nop;
    logic                                            exp_done;
    logic [PAUSE_BITS-1:0]                           exp_pause_len;
    logic                                            exp_dci_dq;
    logic                                            exp_dci_dqs;
    phy_cmd_pkg::tri_word_t                          exp_dqs_data;
    phy_cmd_pkg::tri_word_t                          exp_dq_tri;
    phy_cmd_pkg::tri_word_t                          exp_dqs_tri;

    tb_clk_gen clk_gen (
        .mclk (mclk),
        .mrst (mrst)
    );

    phy_cmd #(
        .CMD_PAUSE_BITS (PAUSE_BITS),
        .CMD_DONE_BIT   (DONE_BIT)
    ) i_dut (
        .mclk, .mrst, .cmd_word, .add_pause, .ddr_cke, .dqs_pattern,
        .dq_tri_on_pattern   (dq_on),
        .dq_tri_off_pattern  (dq_off),
        .dqs_tri_on_pattern  (dqs_on),
        .dqs_tri_off_pattern (dqs_off),
        .cmd_nop, .cmd_add_pause, .pause_len, .sequence_done,
        .buf_wr, .buf_rd, .buf_rst,
        .lane_a, .lane_ba, .lane_ras, .lane_cas, .lane_we, .lane_cke, .lane_odt,
        .dqs_data, .dci_dis_dq, .dci_dis_dqs, .dq_tri, .dqs_tri
    );

    // one command pin over both half-cycles, active low in the selected half
    function automatic logic [1:0] cmd_lane(input logic pin, input logic half);
        return half ? {~pin, 1'b1} : {1'b1, ~pin};
    endfunction

    function automatic phy_cmd_pkg::tri_word_t tri_expect(input logic en, input logic en_prev,
                                                          input logic [HW-1:0] on_pat,
                                                          input logic [HW-1:0] off_pat);
        if (en && !en_prev) return {2{on_pat}};     // lines turn on
        if (!en && en_prev) return {2{off_pat}};    // lines turn off
        return {phy_cmd_pkg::TRI_W{~en}};           // steady, 1 = released
    endfunction

    assign cur_rcw    = cmd_word[phy_cmd_pkg::POS_RCW +: phy_cmd_pkg::RCW_W];
    assign cur_addr   = cmd_word[phy_cmd_pkg::POS_ADDR +: phy_cmd_pkg::ADDR_W];
    assign cur_active = (cur_rcw != '0) && !add_pause;
    assign exp_ctl    = add_pause ? rec_word : cmd_word;   // pause repeats the last controls
    assign exp_loc    = cur_active ? cmd_word : rec_word;  // address stays calm otherwise
    assign exp_rcw    = add_pause ? '0 : cur_rcw;
    assign exp_sel    = exp_ctl[phy_cmd_pkg::POS_SEL];
    assign exp_cmd    = {cmd_lane(exp_rcw[2], exp_sel), cmd_lane(exp_rcw[1], exp_sel),
                         cmd_lane(exp_rcw[0], exp_sel)};
    assign exp_lane_a  = {2{exp_loc[phy_cmd_pkg::POS_ADDR +: phy_cmd_pkg::ADDR_W]}};
    assign exp_lane_ba = {2{exp_loc[phy_cmd_pkg::POS_BANK +: phy_cmd_pkg::BANK_W]}};
    assign exp_cke     = {2{exp_ctl[phy_cmd_pkg::POS_CKE_DIS] ^ ddr_cke}};
    assign exp_odt     = {2{exp_ctl[phy_cmd_pkg::POS_ODT]}};
    assign exp_buf     = {exp_ctl[phy_cmd_pkg::POS_BUF_WR], exp_ctl[phy_cmd_pkg::POS_BUF_RD],
                          exp_ctl[phy_cmd_pkg::POS_BUF_RST]};
    assign exp_nop       = (cur_rcw == '0) && !add_pause;
    assign exp_done      = exp_nop && cur_addr[DONE_BIT];
    assign exp_pause_len = cur_addr[DONE_BIT] ? '0 : cur_addr[PAUSE_BITS-1:0];
    assign exp_dci_dq    = ~exp_ctl[phy_cmd_pkg::POS_DCI_EN];
    assign exp_dci_dqs   = exp_dci_dq | exp_ctl[phy_cmd_pkg::POS_ODT];  // write leveling
    assign exp_dqs_data  = exp_ctl[phy_cmd_pkg::POS_DQS_TOGGLE] ? dqs_pattern : '0;
    assign exp_dq_tri    = tri_expect(exp_ctl[phy_cmd_pkg::POS_DQ_EN],
                                      prev_ctl[phy_cmd_pkg::POS_DQ_EN], dq_on, dq_off);
    assign exp_dqs_tri   = tri_expect(exp_ctl[phy_cmd_pkg::POS_DQS_EN],
                                      prev_ctl[phy_cmd_pkg::POS_DQS_EN], dqs_on, dqs_off);

    always @(negedge mclk) fall_cnt++;

    task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        err_cnt++;
        $display("[ERROR] %0t ns %s: expected %0h, actual %0h", $time, name, exp_v, act_v);
    endtask

    assert property (@(posedge mclk) disable iff (mrst) {lane_ras, lane_cas, lane_we} == exp_cmd)
        else report_mismatch("lane_ras/cas/we", $sampled(exp_cmd),
                             $sampled({lane_ras, lane_cas, lane_we}));
    assert property (@(posedge mclk) disable iff (mrst) lane_a == exp_lane_a)
        else report_mismatch("lane_a", $sampled(exp_lane_a), $sampled(lane_a));
    assert property (@(posedge mclk) disable iff (mrst) lane_ba == exp_lane_ba)
        else report_mismatch("lane_ba", $sampled(exp_lane_ba), $sampled(lane_ba));
    assert property (@(posedge mclk) disable iff (mrst) lane_cke == exp_cke)
        else report_mismatch("lane_cke", $sampled(exp_cke), $sampled(lane_cke));
    assert property (@(posedge mclk) disable iff (mrst) lane_odt == exp_odt)
        else report_mismatch("lane_odt", $sampled(exp_odt), $sampled(lane_odt));
    assert property (@(posedge mclk) disable iff (mrst) {buf_wr, buf_rd, buf_rst} == exp_buf)
        else report_mismatch("buf_wr/rd/rst", $sampled(exp_buf),
                             $sampled({buf_wr, buf_rd, buf_rst}));
    assert property (@(posedge mclk) disable iff (mrst) cmd_nop == exp_nop)
        else report_mismatch("cmd_nop", $sampled(exp_nop), $sampled(cmd_nop));
    assert property (@(posedge mclk) disable iff (mrst)
        cmd_add_pause == cmd_word[phy_cmd_pkg::POS_ADD_PAUSE])
        else report_mismatch("cmd_add_pause", $sampled(cmd_word[phy_cmd_pkg::POS_ADD_PAUSE]),
                             $sampled(cmd_add_pause));
    assert property (@(posedge mclk) disable iff (mrst) pause_len == exp_pause_len)
        else report_mismatch("pause_len", $sampled(exp_pause_len), $sampled(pause_len));
    assert property (@(posedge mclk) disable iff (mrst) sequence_done == exp_done)
        else report_mismatch("sequence_done", $sampled(exp_done), $sampled(sequence_done));
    assert property (@(posedge mclk) disable iff (mrst) dci_dis_dq == exp_dci_dq)
        else report_mismatch("dci_dis_dq", $sampled(exp_dci_dq), $sampled(dci_dis_dq));
    assert property (@(posedge mclk) disable iff (mrst) dci_dis_dqs == exp_dci_dqs)
        else report_mismatch("dci_dis_dqs", $sampled(exp_dci_dqs), $sampled(dci_dis_dqs));
    assert property (@(posedge mclk) disable iff (mrst) dqs_data == exp_dqs_data)
        else report_mismatch("dqs_data", $sampled(exp_dqs_data), $sampled(dqs_data));
    assert property (@(posedge mclk) disable iff (mrst) dq_tri == exp_dq_tri)
        else report_mismatch("dq_tri", $sampled(exp_dq_tri), $sampled(dq_tri));
    assert property (@(posedge mclk) disable iff (mrst) dqs_tri == exp_dqs_tri)
        else report_mismatch("dqs_tri", $sampled(exp_dqs_tri), $sampled(dqs_tri));

    // turn state of each sequencer marks exactly the cycles where the enable changes
    assert property (@(posedge mclk) disable iff (mrst)
        (i_dut.dq_seq.cur_state == phy_cmd_pkg::TRI_TURN) ==
        (exp_ctl[phy_cmd_pkg::POS_DQ_EN] != prev_ctl[phy_cmd_pkg::POS_DQ_EN]))
        else report_mismatch("dq_seq.cur_state turn",
                             $sampled(exp_ctl[phy_cmd_pkg::POS_DQ_EN] !=
                                      prev_ctl[phy_cmd_pkg::POS_DQ_EN]),
                             $sampled(i_dut.dq_seq.cur_state == phy_cmd_pkg::TRI_TURN));
    assert property (@(posedge mclk) disable iff (mrst)
        (i_dut.dqs_seq.cur_state == phy_cmd_pkg::TRI_TURN) ==
        (exp_ctl[phy_cmd_pkg::POS_DQS_EN] != prev_ctl[phy_cmd_pkg::POS_DQS_EN]))
        else report_mismatch("dqs_seq.cur_state turn",
                             $sampled(exp_ctl[phy_cmd_pkg::POS_DQS_EN] !=
                                      prev_ctl[phy_cmd_pkg::POS_DQS_EN]),
                             $sampled(i_dut.dqs_seq.cur_state == phy_cmd_pkg::TRI_TURN));

    // first cycle out of reset with an idle word
    assert property (@(posedge mclk) $fell(mrst) && cmd_word == '0 && !add_pause |->
        lane_a == '0 && lane_ba == '0)
        else report_mismatch("reset lane_a/lane_ba", '0, $sampled({lane_a, lane_ba}));
    assert property (@(posedge mclk) $fell(mrst) && cmd_word == '0 && !add_pause |->
        dq_tri == '1 && dqs_tri == '1)
        else report_mismatch("reset dq_tri/dqs_tri", 16'hffff, $sampled({dq_tri, dqs_tri}));
    assert property (@(posedge mclk) $fell(mrst) && cmd_word == '0 && !add_pause |->
        {buf_wr, buf_rd, buf_rst} == '0)
        else report_mismatch("reset buf_wr/rd/rst", '0, $sampled({buf_wr, buf_rd, buf_rst}));

    task automatic wait_fall();
        int start;
        int waited;
        start  = fall_cnt;
        waited = 0;
        while (fall_cnt == start && waited < WAIT_LIMIT) begin
            #1;
            waited++;
        end
        if (fall_cnt == start) begin
            $display("timeout: mclk had no falling edge within %0d ns", WAIT_LIMIT);
            $display("Test failed");
            $finish;
        end
    endtask

    // one command cycle, sampled by the next rising edge
    task automatic drive(input phy_cmd_pkg::cmd_word_t word, input logic pause);
        prev_ctl = exp_ctl;      // enables the sequencers register at this edge
        if (cur_active) begin
            rec_word = cmd_word;
        end
        cmd_word  = word;
        add_pause = pause;
        wait_fall();
    endtask

    function automatic phy_cmd_pkg::cmd_word_t active_word();
        phy_cmd_pkg::cmd_word_t w;
        w = $urandom;
        if (w[phy_cmd_pkg::POS_RCW +: phy_cmd_pkg::RCW_W] == '0) begin
            w[phy_cmd_pkg::POS_RCW] = 1'b1;     // avoid nop
        end
        return w;
    endfunction

    function automatic phy_cmd_pkg::cmd_word_t nop_word(input logic done);
        phy_cmd_pkg::cmd_word_t w;
        w = $urandom;
        w[phy_cmd_pkg::POS_RCW +: phy_cmd_pkg::RCW_W] = '0;
        w[phy_cmd_pkg::POS_ADDR + DONE_BIT]           = done;
        return w;
    endfunction

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            tests_ok++;
            $display("%s ok", name);
        end else begin
            tests_bad++;
            $display("%s %0d error(s)", name, err_cnt - errs_before);
        end
    endtask

    task automatic check_reset();
        int errs;
        int waited;
        errs   = err_cnt;
        waited = 0;
        while (mrst && waited < WAIT_LIMIT) begin
            #1;
            waited++;
        end
        if (mrst) begin
            $display("timeout: mrst still high after %0d ns", WAIT_LIMIT);
            $display("Test failed");
            $finish;
        end else begin
            drive('0, 1'b0);        // idle word on the first cycle out of reset
            report_test("reset", errs);
        end
    endtask

    task automatic check_active();
        int errs;
        errs = err_cnt;
        repeat (40) begin
            ddr_cke     = 1'($urandom);
            dqs_pattern = phy_cmd_pkg::tri_word_t'($urandom);
            drive(active_word(), 1'b0);
        end
        report_test("active commands", errs);
    endtask

    task automatic check_nop();
        int errs;
        errs = err_cnt;
        repeat (8) begin
            drive(active_word(), 1'b0);
            drive(nop_word(1'b0), 1'b0);        // pause length
            drive(nop_word(1'b1), 1'b0);        // end of sequence
            drive(nop_word(1'($urandom)), 1'b0);
        end
        report_test("nop words", errs);
    endtask

    task automatic check_pause();
        int errs;
        phy_cmd_pkg::cmd_word_t w;
        errs = err_cnt;
        repeat (8) begin
            w = active_word();
            drive(w, 1'b0);
            drive(~w, 1'b1);                    // all control bits differ from the record
            drive($urandom, 1'b1);
            drive(nop_word(1'b0), 1'b0);
        end
        report_test("inserted pause", errs);
    endtask

    task automatic check_tri();
        int errs;
        phy_cmd_pkg::cmd_word_t w;
        logic [15:0] dq_seq;
        logic [15:0] dqs_seq;
        errs    = err_cnt;
        dq_seq  = 16'b0110_0111_0010_1100;     // steady off/on, single-cycle pulses
        dqs_seq = 16'b1001_1100_0110_1011;
        dq_on   = 4'b0011;                     // mixed and distinct, a swap shows up
        dq_off  = 4'b1100;
        dqs_on  = 4'b0001;
        dqs_off = 4'b0111;
        for (int i = 0; i < 16; i++) begin
            w = $urandom;
            w[phy_cmd_pkg::POS_DQ_EN]  = dq_seq[i];
            w[phy_cmd_pkg::POS_DQS_EN] = dqs_seq[i];
            drive(w, 1'b0);
        end
        report_test("tristate sequencing", errs);
    endtask

    task automatic check_dci();
        int errs;
        errs = err_cnt;
        repeat (32) begin
            dqs_pattern = phy_cmd_pkg::tri_word_t'($urandom);
            ddr_cke     = 1'($urandom);
            drive($urandom, ($urandom % 4) == 0);  // mix of commands, nops and pauses
        end
        report_test("dci and dqs data", errs);
    endtask

    initial begin
        cmd_word    = '0;
        add_pause   = 1'b0;
        ddr_cke     = 1'b0;
        dqs_pattern = '0;
        dq_on       = '0;
        dq_off      = '0;
        dqs_on      = '0;
        dqs_off     = '0;
        rec_word    = '0;
        prev_ctl    = '0;
        fall_cnt    = 0;
        err_cnt     = 0;
        tests_ok    = 0;
        tests_bad   = 0;
        void'($urandom(SEED));

        check_reset();
        check_active();
        check_nop();
        check_pause();
        check_tri();
        check_dci();
        drive('0, 1'b0);

        $display("%0d tests ok, %0d tests with errors, %0d errors in total",
                 tests_ok, tests_bad, err_cnt);
        if (err_cnt == 0 && tests_bad == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
verilog/phy_cmd_pkg.sv
verilog/phy_cmd_decode.sv
verilog/phy_cmd_lanes.sv
verilog/phy_tri_seq.sv
verilog/phy_cmd.sv
bench/tb_clk_gen.sv
bench/phy_cmd_tb.sv
